/* rtl/axi2axil_pkg.sv */
// ---------------------------------------------------------------------
// Shared definitions for the AXI4 to AXI4-Lite bridge
// Field widths, tracker depth, burst and response encodings,
// and the packed payloads of every channel
// ---------------------------------------------------------------------
`default_nettype none

package axi2axil_pkg;

  // Field widths
  localparam int addr_width = 16;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;
  localparam int id_width = 4;
  localparam int len_width = 8;
  localparam int size_width = 3;
  localparam int burst_width = 2;
  localparam int resp_width = 2;
  localparam int prot_width = 3;

  // Response tracker depth, also the outstanding request limit
  localparam int max_outstanding = 8;
  localparam int track_ptr_width = $clog2(max_outstanding);
  localparam int track_cnt_width = $clog2(max_outstanding + 1);

  // AXI burst type encoding
  typedef enum logic [burst_width-1:0] {
    burst_fixed    = 2'b00,
    burst_incr     = 2'b01,
    burst_wrap     = 2'b10,
    burst_reserved = 2'b11
  } burst_t;

  // AXI response encoding
  typedef enum logic [resp_width-1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_t;

  // AXI4 address channel request (ar and aw)
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [id_width-1:0]   id;
    logic [len_width-1:0]  len;
    logic [size_width-1:0] size;
    burst_t                burst;
    logic [prot_width-1:0] prot;
  } axi_addr_t;

  // AXI4-Lite address channel request
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [prot_width-1:0] prot;
  } axil_addr_t;

  // One write beat
  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
  } wdata_t;

  // One read beat, same on both sides
  typedef struct packed {
    logic [data_width-1:0] data;
    resp_t                 resp;
  } rdata_t;

  // Tracker entry, burst id and last-beat flag
  typedef struct packed {
    logic [id_width-1:0] id;
    logic                last;
  } track_t;

endpackage

`default_nettype wire

/* rtl/axi2axil_resp_tracker.sv */
// ---------------------------------------------------------------------
// Response tracker FIFO
// Holds id and last flag of every AXI4-Lite request in flight
// Head entry drives the pop side directly
// ---------------------------------------------------------------------
`default_nettype none

module axi2axil_resp_tracker
  import axi2axil_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  // One push per issued request
  input  logic   push_valid,
  output logic   push_ready,
  input  track_t push_data,
  // One pop per returned response
  output logic   pop_valid,
  input  logic   pop_ready,
  output track_t pop_data
);

  // Entry storage
  track_t mem [max_outstanding];

  logic [track_ptr_width-1:0] wr_ptr;
  logic [track_ptr_width-1:0] rd_ptr;
  logic [track_cnt_width-1:0] count;
  logic                       push_hs;
  logic                       pop_hs;

  // Pointer advance with wrap at the last slot
  function automatic logic [track_ptr_width-1:0] next_ptr(
    input logic [track_ptr_width-1:0] ptr
  );
    if (ptr == track_ptr_width'(max_outstanding - 1)) begin
      next_ptr = '0;
    end else begin
      next_ptr = ptr + 1'b1;
    end
  endfunction

  // ---------------------------------------------------------------------
  // Status and handshakes
  // ---------------------------------------------------------------------

  assign push_ready = (count != track_cnt_width'(max_outstanding));
  assign pop_valid  = (count != '0);
  assign push_hs    = push_valid && push_ready;
  assign pop_hs     = pop_valid && pop_ready;

  // Head entry drives pop data with no bypass from the push side
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push_hs) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_hs) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_hs) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Simultaneous push and pop leaves the count unchanged
      case ({push_hs, pop_hs})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // Checks on the caller
  // ---------------------------------------------------------------------

  // Core must gate its requests on push_ready
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    push_valid |-> push_ready);

  // A response pop needs a matching request in flight
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    pop_ready |-> pop_valid);

endmodule

`default_nettype wire

/* rtl/axi2axil_core.sv */
// ---------------------------------------------------------------------
// Burst splitting core for one direction
// Beat counter, per-beat address generation, request gating,
// response tracking and write response merging
// ---------------------------------------------------------------------
`default_nettype none

module axi2axil_core
  import axi2axil_pkg::*;
#(
  // 1 for the read side, 0 for the write side
  parameter bit is_read = 1'b0
) (
  input  logic                clk,
  input  logic                arst_n,
  // AXI4 request
  input  axi_addr_t           axi_req,
  input  logic                axi_req_valid,
  output logic                axi_req_ready,
  // AXI4-Lite request
  output axil_addr_t          axil_req,
  output logic                axil_req_valid,
  input  logic                axil_req_ready,
  // AXI4-Lite response
  input  rdata_t              axil_resp,
  input  logic                axil_resp_valid,
  output logic                axil_resp_ready,
  // AXI4 response
  output rdata_t              axi_resp,
  output logic [id_width-1:0] axi_resp_id,
  output logic                axi_resp_last,
  output logic                axi_resp_valid,
  input  logic                axi_resp_ready
);

  // Current beat index within the burst
  logic [len_width-1:0] beat_cnt;
  logic                 is_last_beat;
  logic                 axil_req_hs;
  logic                 axil_resp_hs;

  // Tracker side
  logic   trk_push_ready;
  logic   trk_pop_valid;
  track_t trk_push_data;
  track_t trk_pop_data;

  // ---------------------------------------------------------------------
  // Beat address
  // ---------------------------------------------------------------------

  // INCR steps by the beat size, WRAP folds back inside its window,
  // FIXED repeats the start address
  function automatic logic [addr_width-1:0] beat_addr(
    input axi_addr_t            req,
    input logic [len_width-1:0] index
  );
    logic [addr_width-1:0] incr_addr;
    logic [addr_width-1:0] wrap_mask;
    incr_addr = req.addr + (addr_width'(index) << req.size);
    // Window size is (len + 1) beats of 2^size bytes
    wrap_mask = (addr_width'({1'b0, req.len} + 9'd1) << req.size) - 1'b1;
    case (req.burst)
      burst_incr: beat_addr = incr_addr;
      burst_wrap: beat_addr = (req.addr & ~wrap_mask) | (incr_addr & wrap_mask);
      default:    beat_addr = req.addr;
    endcase
  endfunction

  // ---------------------------------------------------------------------
  // Request side
  // ---------------------------------------------------------------------

  assign axil_req_hs  = axil_req_valid && axil_req_ready;
  assign axil_resp_hs = axil_resp_valid && axil_resp_ready;
  assign is_last_beat = (beat_cnt == axi_req.len);

  // Issue beats only while the tracker has a free slot
  assign axil_req_valid = axi_req_valid && trk_push_ready;

  // AXI4 request retires together with its final beat
  assign axi_req_ready = axil_req_hs && is_last_beat;

  assign axil_req.addr = beat_addr(axi_req, beat_cnt);
  assign axil_req.prot = axi_req.prot;

  // Beat counter, reloads after the final beat
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_cnt <= '0;
    end else if (axil_req_hs) begin
      if (is_last_beat) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Outstanding request tracking
  // ---------------------------------------------------------------------

  assign trk_push_data.id   = axi_req.id;
  assign trk_push_data.last = is_last_beat;

  axi2axil_resp_tracker u_resp_tracker (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (axil_req_hs),
    .push_ready (trk_push_ready),
    .push_data  (trk_push_data),
    .pop_valid  (trk_pop_valid),
    .pop_ready  (axil_resp_hs),
    .pop_data   (trk_pop_data)
  );

  // Id and last of the oldest request in flight
  assign axi_resp_id   = trk_pop_data.id;
  assign axi_resp_last = trk_pop_data.last;

  // ---------------------------------------------------------------------
  // Response side
  // ---------------------------------------------------------------------

  generate
    if (is_read) begin : gen_read
      // Every R beat goes straight through
      assign axi_resp        = axil_resp;
      assign axi_resp_valid  = axil_resp_valid;
      assign axil_resp_ready = axi_resp_ready;
    end else begin : gen_write
      resp_t merged_resp;
      logic  axi_resp_hs;
      logic  head_last;

      assign axi_resp_hs = axi_resp_valid && axi_resp_ready;
      // Last flag only counts while an entry is present
      assign head_last   = trk_pop_valid && trk_pop_data.last;

      // Only the final B beat of a burst reaches the AXI4 side
      assign axi_resp_valid  = axil_resp_valid && head_last;
      // Earlier beats are absorbed without waiting on bready
      assign axil_resp_ready = !head_last || axi_resp_ready;

      assign axi_resp.data = axil_resp.data;
      // Latest error wins, else whatever was merged so far
      assign axi_resp.resp = (axil_resp.resp != resp_okay) ? axil_resp.resp : merged_resp;

      // Error collected over the non-final beats
      always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
          merged_resp <= resp_okay;
        end else if (axi_resp_hs) begin
          merged_resp <= resp_okay;
        end else if (axil_resp_hs && (axil_resp.resp != resp_okay)) begin
          merged_resp <= axil_resp.resp;
        end
      end
    end
  endgenerate

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------

  // Reserved burst type is never issued by the master
  a_no_reserved_burst: assert property (@(posedge clk) disable iff (!arst_n)
    axi_req_valid |-> (axi_req.burst != burst_reserved));

  // Target may only answer requests it has been sent
  a_resp_has_request: assert property (@(posedge clk) disable iff (!arst_n)
    axil_resp_valid |-> trk_pop_valid);

endmodule

`default_nettype wire

/* rtl/axi2axil_bridge.sv */
// ---------------------------------------------------------------------
// AXI4 to AXI4-Lite bridge top level
// Read core on ar/r, write core on aw/b, W passes straight through
// ---------------------------------------------------------------------
`default_nettype none

module axi2axil_bridge
  import axi2axil_pkg::*;
(
  input  logic                clk,
  input  logic                arst_n,
  // AXI4 read address
  input  axi_addr_t           ar,
  input  logic                ar_valid,
  output logic                ar_ready,
  // AXI4 write address
  input  axi_addr_t           aw,
  input  logic                aw_valid,
  output logic                aw_ready,
  // AXI4 write data
  input  wdata_t              w,
  input  logic                w_last,
  input  logic                w_valid,
  output logic                w_ready,
  // AXI4 read data
  output rdata_t              r,
  output logic [id_width-1:0] r_id,
  output logic                r_last,
  output logic                r_valid,
  input  logic                r_ready,
  // AXI4 write response
  output resp_t               b,
  output logic [id_width-1:0] b_id,
  output logic                b_valid,
  input  logic                b_ready,
  // AXI4-Lite read address
  output axil_addr_t          axil_ar,
  output logic                axil_ar_valid,
  input  logic                axil_ar_ready,
  // AXI4-Lite write address
  output axil_addr_t          axil_aw,
  output logic                axil_aw_valid,
  input  logic                axil_aw_ready,
  // AXI4-Lite write data
  output wdata_t              axil_w,
  output logic                axil_w_valid,
  input  logic                axil_w_ready,
  // AXI4-Lite read data
  input  rdata_t              axil_r,
  input  logic                axil_r_valid,
  output logic                axil_r_ready,
  // AXI4-Lite write response
  input  resp_t               axil_b,
  input  logic                axil_b_valid,
  output logic                axil_b_ready
);

  // Write core response words where B uses only resp
  rdata_t wr_resp_in;
  rdata_t wr_resp_out;

  // ---------------------------------------------------------------------
  // Read direction
  // ---------------------------------------------------------------------

  axi2axil_core #(
    .is_read (1'b1)
  ) u_read_core (
    .clk             (clk),
    .arst_n          (arst_n),
    .axi_req         (ar),
    .axi_req_valid   (ar_valid),
    .axi_req_ready   (ar_ready),
    .axil_req        (axil_ar),
    .axil_req_valid  (axil_ar_valid),
    .axil_req_ready  (axil_ar_ready),
    .axil_resp       (axil_r),
    .axil_resp_valid (axil_r_valid),
    .axil_resp_ready (axil_r_ready),
    .axi_resp        (r),
    .axi_resp_id     (r_id),
    .axi_resp_last   (r_last),
    .axi_resp_valid  (r_valid),
    .axi_resp_ready  (r_ready)
  );

  // ---------------------------------------------------------------------
  // Write direction
  // ---------------------------------------------------------------------

  assign wr_resp_in.data = '0;
  assign wr_resp_in.resp = axil_b;
  assign b               = wr_resp_out.resp;

  // B has no last flag, the write core raises it only on the final beat
  axi2axil_core #(
    .is_read (1'b0)
  ) u_write_core (
    .clk             (clk),
    .arst_n          (arst_n),
    .axi_req         (aw),
    .axi_req_valid   (aw_valid),
    .axi_req_ready   (aw_ready),
    .axil_req        (axil_aw),
    .axil_req_valid  (axil_aw_valid),
    .axil_req_ready  (axil_aw_ready),
    .axil_resp       (wr_resp_in),
    .axil_resp_valid (axil_b_valid),
    .axil_resp_ready (axil_b_ready),
    .axi_resp        (wr_resp_out),
    .axi_resp_id     (b_id),
    .axi_resp_last   (),
    .axi_resp_valid  (b_valid),
    .axi_resp_ready  (b_ready)
  );

  // W beats map one to one onto the AXI4-Lite beats
  // The write core counter marks the burst end, so w_last stays unused
  assign axil_w       = w;
  assign axil_w_valid = w_valid;
  assign w_ready      = axil_w_ready;

endmodule

`default_nettype wire

/* verification/axil_target_model.sv */
// ----------------------------------------------------------------------
// AXI4-Lite target memory model
// 256-word memory, SLVERR window at 0x0800..0x08FF,
// random ready back-pressure from a Galois LFSR
// ----------------------------------------------------------------------
`default_nettype none

module axil_target_model
  import axi2axil_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  axil_addr_t ar,
  input  logic       ar_valid,
  output logic       ar_ready,
  input  axil_addr_t aw,
  input  logic       aw_valid,
  output logic       aw_ready,
  input  wdata_t     w,
  input  logic       w_valid,
  output logic       w_ready,
  output rdata_t     r,
  output logic       r_valid,
  input  logic       r_ready,
  output resp_t      b,
  output logic       b_valid,
  input  logic       b_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [data_width-1:0] mem [256];
  logic [31:0]           lfsr;
  logic [31:0]           lfsr_1;
  logic [31:0]           lfsr_2;
  logic                  rd_go;
  logic                  wr_go;
  logic                  rd_accept;
  logic                  wr_accept;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic in_error_window(input logic [addr_width-1:0] a);
    in_error_window = (a[15:8] == 8'h08);
  endfunction

  // Power-up content, tied to the word index
  function automatic logic [data_width-1:0] fill_word(input int idx);
    fill_word = 32'hc0de_0000 | (32'(idx) << 2);
  endfunction

  // Two random bits per cycle, one per direction
  assign lfsr_1 = lfsr_next(lfsr);
  assign lfsr_2 = lfsr_next(lfsr_1);

  // A request is taken only when its response slot frees up
  assign rd_accept = ar_valid && rd_go && (!r_valid || r_ready);
  assign wr_accept = aw_valid && w_valid && wr_go && (!b_valid || b_ready);
  assign ar_ready  = rd_accept;
  assign aw_ready  = wr_accept;
  assign w_ready   = wr_accept;

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lfsr    <= 32'h5b63;
      rd_go   <= 1'b0;
      wr_go   <= 1'b0;
      r       <= '0;
      r_valid <= 1'b0;
      b       <= resp_okay;
      b_valid <= 1'b0;
      for (int i = 0; i < 256; i++) begin
        mem[i] <= fill_word(i);
      end
    end else begin
      rd_go <= lfsr[0];
      wr_go <= lfsr_1[0];
      lfsr  <= lfsr_2;
      // Read response register
      if (rd_accept) begin
        r_valid <= 1'b1;
        if (in_error_window(ar.addr)) begin
          r.data <= '0;
          r.resp <= resp_slverr;
        end else begin
          r.data <= mem[ar.addr[9:2]];
          r.resp <= resp_okay;
        end
      end else if (r_valid && r_ready) begin
        r_valid <= 1'b0;
      end
      // Write response register, error window drops the data
      if (wr_accept) begin
        b_valid <= 1'b1;
        if (in_error_window(aw.addr)) begin
          b <= resp_slverr;
        end else begin
          b <= resp_okay;
          for (int k = 0; k < strb_width; k++) begin
            if (w.strb[k]) begin
              mem[aw.addr[9:2]][8*k +: 8] <= w.data[8*k +: 8];
            end
          end
        end
      end else if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* verification/axi2axil_tb.sv */
// ----------------------------------------------------------------------
// Testbench for the AXI4 to AXI4-Lite bridge
// Clock and reset, table-driven AXI4 master, random response
// back-pressure, per-beat checks and closing summary
// ----------------------------------------------------------------------
`default_nettype none

module axi2axil_tb
  import axi2axil_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int wait_limit = 2000;
  localparam int max_tests  = 32;

  logic                clk;
  logic                arst_n;
  axi_addr_t           ar;
  logic                ar_valid;
  logic                ar_ready;
  axi_addr_t           aw;
  logic                aw_valid;
  logic                aw_ready;
  wdata_t              w;
  logic                w_last;
  logic                w_valid;
  logic                w_ready;
  rdata_t              r;
  logic [id_width-1:0] r_id;
  logic                r_last;
  logic                r_valid;
  logic                r_ready = 1'b0;
  resp_t               b;
  logic [id_width-1:0] b_id;
  logic                b_valid;
  logic                b_ready = 1'b0;
  axil_addr_t          axil_ar;
  logic                axil_ar_valid;
  logic                axil_ar_ready;
  axil_addr_t          axil_aw;
  logic                axil_aw_valid;
  logic                axil_aw_ready;
  wdata_t              axil_w;
  logic                axil_w_valid;
  logic                axil_w_ready;
  rdata_t              axil_r;
  logic                axil_r_valid;
  logic                axil_r_ready;
  resp_t               axil_b;
  logic                axil_b_valid;
  logic                axil_b_ready;

  // Test table with eight hex words per burst
  logic [31:0] tests [0:8*max_tests-1];
  // Expected target memory content
  logic [31:0] shadow [256];
  logic [31:0] lfsr = 32'h5b63;
  int          checks = 0;
  int          errors = 0;

  axi2axil_bridge u_axi2axil_bridge (.*);

  axil_target_model u_axil_target_model (
    .clk      (clk),
    .arst_n   (arst_n),
    .ar       (axil_ar),
    .ar_valid (axil_ar_valid),
    .ar_ready (axil_ar_ready),
    .aw       (axil_aw),
    .aw_valid (axil_aw_valid),
    .aw_ready (axil_aw_ready),
    .w        (axil_w),
    .w_valid  (axil_w_valid),
    .w_ready  (axil_w_ready),
    .r        (axil_r),
    .r_valid  (axil_r_valid),
    .r_ready  (axil_r_ready),
    .b        (axil_b),
    .b_valid  (axil_b_valid),
    .b_ready  (axil_b_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Byte address of beat k under the burst rules
  function automatic int beat_address(input axi_addr_t req, input int k);
    int start;
    int bytes;
    int window;
    int base;
    start  = int'(req.addr);
    bytes  = 1 << req.size;
    window = bytes * (int'(req.len) + 1);
    base   = start - (start % window);
    case (req.burst)
      burst_incr: beat_address = (start + k * bytes) % 65536;
      burst_wrap: beat_address = base + (start - base + k * bytes) % window;
      default:    beat_address = start;
    endcase
  endfunction

  function automatic logic in_error_window(input int a);
    in_error_window = (a >= 'h0800) && (a <= 'h08ff);
  endfunction

  // Target memory before any write
  function automatic logic [31:0] initial_word(input int idx);
    initial_word = 32'hc0de_0000 + 32'(idx * 4);
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", wait_limit, what);
    $display("Some tests failed");
    $finish;
  endtask

  // Response readies take three LFSR bits per cycle
  always @(posedge clk) begin : ready_gen
    logic [31:0] s1;
    logic [31:0] s2;
    s1 = lfsr_next(lfsr);
    s2 = lfsr_next(s1);
    if (arst_n) begin
      r_ready <= lfsr[0] | s1[0];
      b_ready <= s2[0];
      lfsr    <= lfsr_next(s2);
    end
  end

  // ----------------------------------------------------------------------
  // Master driver and response checkers
  // ----------------------------------------------------------------------

  task automatic send_read(input axi_addr_t req);
    int   k;
    int   guard;
    int   a;
    logic seen;
    @(posedge clk);
    ar       <= req;
    ar_valid <= 1'b1;
    k = 0;
    while (k <= int'(req.len)) begin
      guard = 0;
      seen  = 1'b0;
      while (!seen && guard < wait_limit) begin
        @(negedge clk);
        seen = axil_ar_valid && axil_ar_ready;
        guard++;
      end
      if (!seen) begin
        report_timeout("an AXI4-Lite read request");
        break;
      end
      // AR retires with the final beat only
      check_value($sformatf("arready on beat %0d", k), 32'(ar_ready),
                  32'(k == int'(req.len)));
      a = beat_address(req, k);
      check_value($sformatf("araddr beat %0d", k), 32'(axil_ar.addr), 32'(a));
      check_value($sformatf("arprot beat %0d", k), 32'(axil_ar.prot), 32'(req.prot));
      @(posedge clk);
      k++;
      if (k > int'(req.len)) begin
        ar_valid <= 1'b0;
      end
    end
  endtask

  task automatic send_write(input axi_addr_t req, input logic [31:0] seed);
    int   k;
    int   guard;
    int   a;
    logic seen;
    @(posedge clk);
    aw      <= req;
    aw_valid <= 1'b1;
    w       <= {seed, {strb_width{1'b1}}};
    w_last  <= (req.len == 0);
    w_valid <= 1'b1;
    k = 0;
    while (k <= int'(req.len)) begin
      guard = 0;
      seen  = 1'b0;
      while (!seen && guard < wait_limit) begin
        @(negedge clk);
        seen = w_ready;
        guard++;
      end
      if (!seen) begin
        report_timeout("wready");
        break;
      end
      // AW retires with the final beat only
      check_value($sformatf("awready on beat %0d", k), 32'(aw_ready),
                  32'(k == int'(req.len)));
      a = beat_address(req, k);
      check_value($sformatf("awaddr beat %0d", k), 32'(axil_aw.addr), 32'(a));
      check_value($sformatf("awprot beat %0d", k), 32'(axil_aw.prot), 32'(req.prot));
      if (!in_error_window(a)) begin
        shadow[(a / 4) % 256] = seed + 32'(k);
      end
      @(posedge clk);
      k++;
      if (k > int'(req.len)) begin
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
      end else begin
        w      <= {seed + 32'(k), {strb_width{1'b1}}};
        w_last <= (k == int'(req.len));
      end
    end
  endtask

  task automatic collect_read(input axi_addr_t req, input logic [1:0] exp_resp);
    int          guard;
    int          a;
    logic        seen;
    logic [31:0] exp_data;
    resp_t       exp_beat;
    resp_t       burst_resp;
    burst_resp = resp_okay;
    for (int k = 0; k <= int'(req.len); k++) begin
      guard = 0;
      seen  = 1'b0;
      while (!seen && guard < wait_limit) begin
        @(negedge clk);
        seen = r_valid && r_ready;
        guard++;
      end
      if (!seen) begin
        report_timeout("a read data beat");
        break;
      end
      a = beat_address(req, k);
      if (in_error_window(a)) begin
        exp_data = '0;
        exp_beat = resp_slverr;
      end else begin
        exp_data = shadow[(a / 4) % 256];
        exp_beat = resp_okay;
      end
      if (r.resp != resp_okay) begin
        burst_resp = r.resp;
      end
      check_value($sformatf("rdata id %0h beat %0d", req.id, k), r.data, exp_data);
      check_value($sformatf("rresp id %0h beat %0d", req.id, k), 32'(r.resp), 32'(exp_beat));
      check_value($sformatf("rid beat %0d", k), 32'(r_id), 32'(req.id));
      check_value($sformatf("rlast beat %0d", k), 32'(r_last), 32'(k == int'(req.len)));
      @(posedge clk);
    end
    check_value($sformatf("read burst resp id %0h", req.id), 32'(burst_resp), 32'(exp_resp));
  endtask

  task automatic collect_write(input axi_addr_t req, input logic [1:0] exp_resp);
    int   guard;
    logic seen;
    guard = 0;
    seen  = 1'b0;
    while (!seen && guard < wait_limit) begin
      @(negedge clk);
      seen = b_valid && b_ready;
      guard++;
    end
    if (!seen) begin
      report_timeout("the write response");
    end else begin
      check_value("bid", 32'(b_id), 32'(req.id));
      check_value($sformatf("bresp id %0h", req.id), 32'(b), 32'(exp_resp));
      @(posedge clk);
    end
  endtask

  // Runs one table row with request and response side by side
  task automatic run_burst(input int base);
    axi_addr_t   req;
    logic [31:0] seed;
    logic [1:0]  exp_resp;
    req.id    = tests[base+1][id_width-1:0];
    req.addr  = tests[base+2][addr_width-1:0];
    req.len   = tests[base+3][len_width-1:0];
    req.size  = tests[base+4][size_width-1:0];
    req.burst = burst_t'(tests[base+5][1:0]);
    // Protection bits follow the id so they change from burst to burst
    req.prot  = prot_width'(req.id);
    seed      = tests[base+6];
    exp_resp  = tests[base+7][1:0];
    if (tests[base] == 32'h1) begin
      fork
        send_write(req, seed);
        collect_write(req, exp_resp);
      join
    end else begin
      fork
        send_read(req);
        collect_read(req, exp_resp);
      join
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin : main
    int t;
    arst_n   <= 1'b0;
    ar       <= '0;
    ar_valid <= 1'b0;
    aw       <= '0;
    aw_valid <= 1'b0;
    w        <= '0;
    w_last   <= 1'b0;
    w_valid  <= 1'b0;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = initial_word(i);
    end
    $readmemh("verification/axi2axil_tests.txt", tests);
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    // Idle outputs straight after reset
    @(negedge clk);
    check_value("arready after reset", 32'(ar_ready), 32'h0);
    check_value("awready after reset", 32'(aw_ready), 32'h0);
    check_value("rvalid after reset", 32'(r_valid), 32'h0);
    check_value("bvalid after reset", 32'(b_valid), 32'h0);
    if (^tests[0] === 1'bx) begin
      $display("Test data file is missing or could not be read");
      $display("Some tests failed");
      $finish;
    end else begin
      t = 0;
      // Op code F ends the table
      while (t < max_tests && tests[8*t] != 32'hf) begin
        run_burst(8 * t);
        t++;
      end
      @(negedge clk);
      check_value("rvalid after last burst", 32'(r_valid), 32'h0);
      check_value("bvalid after last burst", 32'(b_valid), 32'h0);
      $display("Bursts: %0d, checks: %0d, errors: %0d", t, checks, errors);
      if (errors == 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* all.f */
rtl/axi2axil_pkg.sv
rtl/axi2axil_resp_tracker.sv
rtl/axi2axil_core.sv
rtl/axi2axil_bridge.sv
verification/axil_target_model.sv
verification/axi2axil_tb.sv

/* verification/axi2axil_tests.txt */
// op (0 read, 1 write, F end)  id  addr  len  size  burst (0 fixed, 1 incr, 2 wrap)
// write data seed, expected burst resp (0 okay, 2 slverr); all fields hex
// INCR write of 4 beats, then read back
1 1 0100 03 2 1 11110000 0
0 1 0100 03 2 1 00000000 0
// WRAP read of 4 beats from the middle of a 16 byte window
1 2 0200 03 2 1 22220000 0
0 3 0208 03 2 2 00000000 0
// WRAP read of 8 beats starting near the top of its window
1 4 0220 07 2 1 44440000 0
0 4 0234 07 2 2 00000000 0
// FIXED write of 3 beats, then a single-beat read
1 5 0300 02 2 0 55550000 0
0 5 0300 00 2 1 00000000 0
// FIXED read of 4 beats
0 6 0300 03 2 0 00000000 0
// Error window on the last write beat, then on the first
1 7 07F4 03 2 1 77770000 2
1 8 08FC 01 2 1 88880000 2
// Reads crossing into and out of the error window
0 9 07F8 03 2 1 00000000 2
0 A 08F8 03 2 1 00000000 2
// Clean write after error bursts, merged resp starts over
1 B 0180 01 2 1 BBBB0000 0
0 B 0180 01 2 1 00000000 0
// Long bursts under back-pressure
1 C 0040 0F 2 1 CCCC0000 0
0 D 0040 0F 2 1 00000000 0
1 E 0380 0F 2 2 EEEE0000 0
0 E 03A0 0F 2 2 00000000 0
// End of table
F 0 0000 00 0 0 00000000 0
